/* convCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module convCtrl
	import convPkg::*;
	(
	input  logic      clk,
	input  logic      rst,
	input  ctrlCmd_e  ctrl,
	input  logic      iValid,
	input  logic      wValid,
	convCtrlIf.ctrl   cif,
	output logic      resValid,
	output logic      finish
);

	convState_e       state;
	convState_e       stateNext;
	logic [colW-1:0]  colCnt;
	logic [passW-1:0] passReg;
	logic             inWait;
	logic             inCompute;
	logic             holdNow;

	assign inWait    = (state == stWait);
	assign inCompute = (state == stCompute);
	assign holdNow   = inCompute && (ctrl == cmdHold);

	// A row beats a weight word offered in the same cycle
	assign cif.rowLoad     = inWait && iValid;
	assign cif.weightLoad  = inWait && !iValid && wValid;
	assign cif.rowRotate   = inCompute;
	assign cif.computeEn   = inCompute;
	assign cif.weightClear = holdNow;
	assign cif.pass        = passReg;

	assign finish = (state == stFinish);

	always_comb begin
		stateNext = state;
		case (state)
			stWait: begin
				if (ctrl == cmdStart) begin
					stateNext = stCompute;
				end else if (ctrl == cmdEnd) begin
					stateNext = stFinish;
				end
			end
			stCompute: begin
				if (ctrl == cmdHold) begin
					stateNext = stWait;
				end else if (ctrl == cmdEnd) begin
					stateNext = stFinish;
				end
			end
			default: stateNext = state; // Finish is left only by reset
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= stWait;
		end else begin
			state <= stateNext;
		end
	end

	// Column and pass counters advance once per compute cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			colCnt  <= '0;
			passReg <= '0;
		end else if (holdNow) begin
			colCnt  <= '0;
			passReg <= '0;
		end else if (inCompute) begin
			if (colCnt == colW'(rowPixels - 1)) begin
				colCnt  <= '0;
				passReg <= passReg + 1'b1; // Next kernel pair
			end else begin
				colCnt <= colCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resValid <= 1'b0;
		end else begin
			resValid <= inCompute; // Sums land one cycle after compute
		end
	end

endmodule

`default_nettype wire

/* convCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface convCtrlIf
	import convPkg::*;
	();

	logic             rowLoad;     // Shift iData into the bank
	logic             rowRotate;   // Circular shift once per compute cycle
	logic             weightLoad;  // Store one weight word
	logic             weightClear;
	logic [passW-1:0] pass;        // Selects the kernel pair
	logic             computeEn;   // Cubes capture their sums

	modport ctrl (output rowLoad, rowRotate, weightLoad, weightClear, pass, computeEn);
	modport rows (input rowLoad, rowRotate);
	modport weights (input weightLoad, weightClear, pass);
	modport cubes (input computeEn);

endinterface

`default_nettype wire

/* convEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module convEngine
	import convPkg::*;
	(
	input  logic      clk,
	input  logic      rst,
	input  ctrlCmd_e  ctrl,
	input  row_t      iData,
	input  logic      iValid,
	input  row_t      wData,
	input  logic      wValid,
	output result_t   res,
	output logic      resValid,
	output logic      finish
);

	window_t                   window;
	kernel_t [kernelSlots-1:0] kernels;

	convCtrlIf cif ();

	convCtrl uCtrl (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.iValid   (iValid),
		.wValid   (wValid),
		.cif      (cif.ctrl),
		.resValid (resValid),
		.finish   (finish)
	);

	rowBank uRows (
		.clk    (clk),
		.rst    (rst),
		.cif    (cif.rows),
		.iData  (iData),
		.window (window)
	);

	weightStore uWeights (
		.clk     (clk),
		.rst     (rst),
		.cif     (cif.weights),
		.wData   (wData),
		.kernels (kernels)
	);

	// Cube s uses kernel slot s/8 at column s%8
	for (genvar s = 0; s < cubeCount; s++) begin : gCube
		macCube #(
			.colOffset (s % rowPixels)
		) uCube (
			.clk       (clk),
			.rst       (rst),
			.computeEn (cif.computeEn),
			.window    (window),
			.kernel    (kernels[s / rowPixels]),
			.sum       (res[s])
		);
	end

endmodule

`default_nettype wire

/* convEngine_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module convCtrlAsserts
	import convPkg::*;
	(
	input logic       clk,
	input logic       rst,
	input convState_e state,
	input logic       rowLoad,
	input logic       weightLoad,
	input logic       resValid
);

	// Finish is a sink until reset
	finishHeld: assert property (@(posedge clk) disable iff (rst)
		state == stFinish |=> state == stFinish)
		else $error("Controller left stFinish without a reset");

	loadsExclusive: assert property (@(posedge clk) disable iff (rst)
		!(rowLoad && weightLoad))
		else $error("rowLoad and weightLoad were high in the same cycle");

	resultAfterCompute: assert property (@(posedge clk) disable iff (rst)
		resValid |-> $past(state) == stCompute)
		else $error("resValid was high without a compute cycle before it");

endmodule

bind convCtrl convCtrlAsserts uAsserts (
	.clk        (clk),
	.rst        (rst),
	.state      (state),
	.rowLoad    (cif.rowLoad),
	.weightLoad (cif.weightLoad),
	.resValid   (resValid)
);

`default_nettype wire

/* convPkg.sv */
`default_nettype none

package convPkg;

	localparam int pixelW      = 8;
	localparam int rowPixels   = 8;
	localparam int rowCount    = 8;
	localparam int windowRows  = 3;
	localparam int kernelTaps  = 9;
	localparam int kernelSlots = 2;  // Kernels in use per pass
	localparam int passCount   = 2;
	localparam int weightWords = 5;  // 4 kernels x 72 bits, whole words
	localparam int sumW        = 20; // 9 x 255 x 255 fits
	localparam int cubeCount   = kernelSlots * rowPixels;

	localparam int wordW    = rowPixels * pixelW;
	localparam int kernelW  = kernelTaps * pixelW;
	localparam int colW     = $clog2(rowPixels);
	localparam int passW    = $clog2(passCount);
	localparam int wordCntW = $clog2(weightWords + 1);

	typedef logic [wordW-1:0] row_t;         // Pixel j at bits 8j upward
	typedef row_t [windowRows-1:0] window_t; // Element 0 is row A
	typedef logic [kernelW-1:0] kernel_t;    // Tap t at bits 8t upward
	typedef logic [sumW-1:0] sum_t;
	typedef sum_t [cubeCount-1:0] result_t;

	typedef enum logic [1:0] {
		cmdEnd   = 2'd0,
		cmdStart = 2'd1,
		cmdHold  = 2'd2,
		cmdIdle  = 2'd3
	} ctrlCmd_e;

	typedef enum logic [1:0] {
		stWait    = 2'd0,
		stCompute = 2'd1,
		stFinish  = 2'd2
	} convState_e;

endpackage

`default_nettype wire

/* macCube.sv */
`timescale 1ns/1ps
`default_nettype none

module macCube
	import convPkg::*;
	#(
	parameter int colOffset = 0 // First window column, 0 to 7
	)(
	input  logic     clk,
	input  logic     rst,
	input  logic     computeEn,
	input  window_t  window,
	input  kernel_t  kernel,
	output sum_t     sum
);

	sum_t total;

	// Nine taps, columns wrap around the row edge
	always_comb begin
		logic [pixelW-1:0]   pix;
		logic [pixelW-1:0]   tap;
		logic [2*pixelW-1:0] prod;
		int                  r;
		int                  c;
		total = '0;
		for (int t = 0; t < kernelTaps; t++) begin
			r     = t / windowRows;
			c     = (colOffset + t % windowRows) % rowPixels;
			pix   = window[r][c*pixelW +: pixelW];
			tap   = kernel[t*pixelW +: pixelW];
			prod  = pix * tap;
			total = total + sum_t'(prod);
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sum <= '0;
		end else if (computeEn) begin
			sum <= total;
		end
	end

endmodule

`default_nettype wire

/* rowBank.sv */
`timescale 1ns/1ps
`default_nettype none

module rowBank
	import convPkg::*;
	(
	input  logic     clk,
	input  logic     rst,
	convCtrlIf.rows  cif,
	input  row_t     iData,
	output window_t  window
);

	row_t rows [rowCount]; // Rows A to H

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < rowCount; i++) begin
				rows[i] <= '0;
			end
		end else if (cif.rowLoad || cif.rowRotate) begin
			for (int i = 0; i < rowCount - 1; i++) begin
				rows[i] <= rows[i + 1];
			end
			if (cif.rowLoad) begin
				rows[rowCount - 1] <= iData; // New row enters at H
			end else begin
				rows[rowCount - 1] <= rows[0]; // Row A wraps to H
			end
		end
	end

	// Window is the three top rows
	always_comb begin
		for (int r = 0; r < windowRows; r++) begin
			window[r] = rows[r];
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tbConvEngine -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/VtbConvEngine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation passed"
exit 0

/* sim.f */
convPkg.sv
convCtrlIf.sv
convCtrl.sv
rowBank.sv
weightStore.sv
macCube.sv
convEngine.sv
convEngine_asserts.sv
tbConvEngine.sv

/* tbConvEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module tbConvEngine
	import convPkg::*;
	();

	localparam int scenarioCount = 4;
	localparam int drainLimit    = 4; // Cycles for the last result to clear
	localparam int finishLimit   = 4;

	typedef struct packed {
		int       rows;       // Rows shifted in during Wait
		int       words;      // Weight words offered
		logic     together;   // Rows and words in the same cycles
		int       cycles;     // Compute cycles
		ctrlCmd_e closeCmd;   // Hold or End
		int       expResults;
	} scenario_t;

	scenario_t scenarios [scenarioCount] = '{
		'{8, 5, 1'b0, 16, cmdHold, 16}, // Both passes and the column wrap
		'{3, 4, 1'b1, 10, cmdHold, 10}, // Words beside rows are lost
		'{0, 0, 1'b0, 8, cmdHold, 8},   // Weights dropped by the last hold
		'{0, 5, 1'b0, 12, cmdEnd, 12}   // Reloaded weights on rotated rows
	};

	logic     clk;
	logic     rst;
	ctrlCmd_e ctrl;
	row_t     iData;
	logic     iValid;
	row_t     wData;
	logic     wValid;
	result_t  res;
	logic     resValid;
	logic     finish;

	// Reference model
	row_t                         mRows [rowCount];
	logic [weightWords*wordW-1:0] mStore;
	int                           mWordCnt;
	int                           mCol;
	logic                         mPass;
	convState_e                   mState;
	logic                         expResValid;
	logic                         expFinish;
	sum_t                         expRes [cubeCount];

	logic [31:0] rngState;
	int          errCount;
	int          timeoutCount;
	int          resSeen;

	convEngine i_dut (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.iData    (iData),
		.iValid   (iValid),
		.wData    (wData),
		.wValid   (wValid),
		.res      (res),
		.resValid (resValid),
		.finish   (finish)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic row_t randRow();
		row_t r;
		r[63:32] = nextRand();
		r[31:0]  = nextRand();
		return r;
	endfunction

	task reportMismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("ERR %s got %h expected %h", name, got, exp);
		errCount++;
	endtask

	task resetModel();
		for (int i = 0; i < rowCount; i++) begin
			mRows[i] = '0;
		end
		for (int s = 0; s < cubeCount; s++) begin
			expRes[s] = '0;
		end
		mStore      = '0;
		mWordCnt    = 0;
		mCol        = 0;
		mPass       = 1'b0;
		mState      = stWait;
		expResValid = 1'b0;
		expFinish   = 1'b0;
	endtask

	// Row A drops out at the top, newRow enters as row H
	task shiftInRow(input row_t newRow);
		for (int i = 0; i < rowCount - 1; i++) begin
			mRows[i] = mRows[i + 1];
		end
		mRows[rowCount - 1] = newRow;
	endtask

	// 3x3 window at the cube's column, wrapping past pixel 7
	function automatic sum_t cubeSum(input int s);
		int         kIdx;
		int         off;
		int         c;
		int         total;
		logic [7:0] pix;
		logic [7:0] w;
		kIdx  = int'(mPass) * kernelSlots + s / rowPixels;
		off   = s % rowPixels;
		total = 0;
		for (int t = 0; t < kernelTaps; t++) begin
			c     = (off + t % 3) % rowPixels;
			pix   = mRows[t / 3][c*8 +: 8];
			w     = mStore[kIdx*kernelW + t*8 +: 8];
			total = total + int'(pix) * int'(w);
		end
		return sum_t'(total);
	endfunction

	task advanceModel(input ctrlCmd_e cmd, input logic iv, input row_t id, input logic wv,
		input row_t wd);
		expResValid = (mState == stCompute); // Result shows up next cycle
		if (mState == stCompute) begin
			for (int s = 0; s < cubeCount; s++) begin
				expRes[s] = cubeSum(s);
			end
		end
		case (mState)
			stWait: begin
				if (iv) begin
					shiftInRow(id);
				end else if (wv && mWordCnt < weightWords) begin
					mStore[mWordCnt*wordW +: wordW] = wd;
					mWordCnt++;
				end
				if (cmd == cmdStart) begin
					mState = stCompute;
				end else if (cmd == cmdEnd) begin
					mState = stFinish;
				end
			end
			stCompute: begin
				shiftInRow(mRows[0]); // Rotation, loads are ignored
				if (cmd == cmdHold) begin
					mStore   = '0;
					mWordCnt = 0;
					mCol     = 0;
					mPass    = 1'b0;
					mState   = stWait;
				end else begin
					mCol++;
					if (mCol == rowPixels) begin
						mCol  = 0;
						mPass = ~mPass; // Second kernel pair
					end
					if (cmd == cmdEnd) begin
						mState = stFinish;
					end
				end
			end
			default: begin
			end
		endcase
		expFinish = (mState == stFinish);
	endtask

	task checkOutputs();
		assert (resValid === expResValid)
			else reportMismatch("resValid", 64'(resValid), 64'(expResValid));
		assert (finish === expFinish)
			else reportMismatch("finish", 64'(finish), 64'(expFinish));
		if (expResValid) begin
			for (int s = 0; s < cubeCount; s++) begin
				assert (res[s] === expRes[s])
					else reportMismatch($sformatf("res[%0d]", s), 64'(res[s]), 64'(expRes[s]));
			end
		end
		if (resValid === 1'b1) begin
			resSeen++;
		end
	endtask

	// Drive at the rising edge, check at the falling edge
	task stepCycle(input ctrlCmd_e cmd, input logic iv, input row_t id, input logic wv,
		input row_t wd);
		@(posedge clk);
		ctrl   <= cmd;
		iValid <= iv;
		iData  <= id;
		wValid <= wv;
		wData  <= wd;
		@(negedge clk);
		checkOutputs();
		advanceModel(cmd, iv, id, wv, wd);
	endtask

	task idleCycle();
		stepCycle(cmdIdle, 1'b0, '0, 1'b0, '0);
	endtask

	task drainResults();
		int waited;
		waited = 0;
		idleCycle();
		while (resValid === 1'b1 && timeoutCount == 0) begin
			if (waited == drainLimit) begin
				$display("Timeout: resValid still high %0d cycles after compute ended", drainLimit);
				timeoutCount++;
			end else begin
				idleCycle();
				waited++;
			end
		end
	endtask

	task waitFinish();
		int waited;
		waited = 0;
		while (finish !== 1'b1 && timeoutCount == 0) begin
			if (waited == finishLimit) begin
				$display("Timeout: finish did not rise within %0d cycles", finishLimit);
				timeoutCount++;
			end else begin
				idleCycle();
				waited++;
			end
		end
	endtask

	task runScenario(input int idx);
		scenario_t   sc;
		int          loads;
		logic [31:0] r;
		sc      = scenarios[idx];
		resSeen = 0;
		if (sc.together) begin
			loads = (sc.rows > sc.words) ? sc.rows : sc.words;
			for (int i = 0; i < loads; i++) begin
				stepCycle(cmdIdle, i < sc.rows, randRow(), i < sc.words, randRow());
			end
		end else begin
			for (int i = 0; i < sc.rows; i++) begin
				stepCycle(cmdIdle, 1'b1, randRow(), 1'b0, '0);
			end
			for (int i = 0; i < sc.words; i++) begin
				stepCycle(cmdIdle, 1'b0, '0, 1'b1, randRow());
			end
		end
		stepCycle(cmdStart, 1'b0, '0, 1'b0, '0);
		for (int c = 1; c <= sc.cycles; c++) begin
			r = nextRand(); // Random loads offered while computing
			stepCycle((c == sc.cycles) ? sc.closeCmd : cmdIdle, r[0], randRow(), r[1], randRow());
		end
		drainResults();
		assert (resSeen == sc.expResults)
			else reportMismatch("resultCount", 64'(resSeen), 64'(sc.expResults));
	endtask

	initial begin
		rst          = 1'b1;
		ctrl         = cmdIdle;
		iData        = '0;
		iValid       = 1'b0;
		wData        = '0;
		wValid       = 1'b0;
		rngState     = 32'h162f083c;
		errCount     = 0;
		timeoutCount = 0;
		resSeen      = 0;
		resetModel();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkOutputs(); // Outputs low out of reset
		for (int i = 0; i < scenarioCount; i++) begin
			if (timeoutCount == 0) begin
				runScenario(i);
			end
		end
		if (timeoutCount == 0) begin
			waitFinish();
		end
		// Start and loads after End stay without effect
		for (int i = 0; i < 4 && timeoutCount == 0; i++) begin
			stepCycle(cmdStart, 1'b1, randRow(), 1'b1, randRow());
		end
		$display("Checks done: %0d value errors, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* weightStore.sv */
`timescale 1ns/1ps
`default_nettype none

module weightStore
	import convPkg::*;
	(
	input  logic                        clk,
	input  logic                        rst,
	convCtrlIf.weights                  cif,
	input  row_t                        wData,
	output kernel_t [kernelSlots-1:0]   kernels
);

	logic [weightWords*wordW-1:0] store;
	logic [wordCntW-1:0]          wordCnt;
	logic                         storeFull;

	assign storeFull = (wordCnt == wordCntW'(weightWords));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			store   <= '0;
			wordCnt <= '0;
		end else if (cif.weightClear) begin
			store   <= '0; // Hold drops all weights
			wordCnt <= '0;
		end else if (cif.weightLoad && !storeFull) begin
			store[wordCnt*wordW +: wordW] <= wData;
			wordCnt                       <= wordCnt + 1'b1;
		end
	end

	// Slot k shows kernel pass*kernelSlots + k
	always_comb begin
		for (int k = 0; k < kernelSlots; k++) begin
			kernels[k] = store[(int'(cif.pass) * kernelSlots + k) * kernelW +: kernelW];
		end
	end

endmodule

`default_nettype wire
